// ==== msr_settings.svh ====
`ifndef MSR_SETTINGS_SVH
`define MSR_SETTINGS_SVH

// Register width and scratch count
`define MSR_DW           32
`define MSR_SR_NUM       4

// CPUID fields
`define MSR_CPUID_VER    8'd1
`define MSR_CPUID_REV    10'd0
`define MSR_CPUID_FIMM   1'b1
`define MSR_CPUID_FDMM   1'b1
`define MSR_CPUID_FICA   1'b0
`define MSR_CPUID_FDCA   1'b0
`define MSR_CPUID_FDBG   1'b0
`define MSR_CPUID_FFPU   1'b0
`define MSR_CPUID_FIRQC  1'b1
`define MSR_CPUID_FTSC   1'b1

// Exception vectors, one slot per cause
`define MSR_EVEC_BASE    32'h0000_0100
`define MSR_EVEC_STRIDE  32'd16

`endif

// ==== msr_pkg.sv ====
`include "msr_settings.svh"

package msr_pkg;

   // Register index, APB address bits 5:2
   typedef enum logic [3:0] {
      MSR_IDX_PSR    = 4'd0,
      MSR_IDX_CPUID  = 4'd1,
      MSR_IDX_EPSR   = 4'd2,
      MSR_IDX_EPC    = 4'd3,
      MSR_IDX_ELSA   = 4'd4,
      MSR_IDX_COREID = 4'd5,
      MSR_IDX_SR0    = 4'd8,
      MSR_IDX_SR1    = 4'd9,
      MSR_IDX_SR2    = 4'd10,
      MSR_IDX_SR3    = 4'd11
   } msr_idx_e;

   typedef struct packed {
      logic [`MSR_DW-9:0] rsvd_hi;
      logic               dmme;
      logic               imme;
      logic               ire;
      logic               rm;
      logic [3:0]         rsvd_lo;
   } msr_psr_t;

   // Same word seen raw or by field
   typedef union packed {
      logic [`MSR_DW-1:0] word;
      msr_psr_t           f;
   } msr_psr_u;

   typedef struct packed {
      logic                   psr_we;
      logic                   epsr_we;
      logic                   epc_we;
      logic                   elsa_we;
      logic [`MSR_SR_NUM-1:0] sr_we;
      logic [`MSR_DW-1:0]     data;
   } msr_wr_t;

   typedef struct packed {
      msr_psr_u                             psr;
      msr_psr_u                             psr_nold;
      msr_psr_u                             epsr;
      msr_psr_u                             epsr_nobyp;
      logic [`MSR_DW-1:0]                   epc;
      logic [`MSR_DW-1:0]                   elsa;
      logic [`MSR_SR_NUM-1:0][`MSR_DW-1:0]  sr;
   } msr_view_t;

   typedef enum logic {
      EXC_ENT = 1'b0,
      EXC_RET = 1'b1
   } exc_kind_e;

   typedef struct packed {
      logic               valid;
      exc_kind_e          kind;
      logic [3:0]         cause;
      logic [`MSR_DW-1:0] pc;
      logic [`MSR_DW-1:0] lsa;
   } exc_evt_t;

   typedef struct packed {
      logic               ent;
      logic               ret;
      logic [`MSR_DW-1:0] epsr_nxt;
      logic [`MSR_DW-1:0] epc_nxt;
      logic [`MSR_DW-1:0] elsa_nxt;
      msr_psr_t           psr_rest;
   } exc_upd_t;

   typedef struct packed {
      logic               valid;
      logic [`MSR_DW-1:0] pc;
   } redirect_t;

endpackage

// ==== msr_file.sv ====
`include "msr_settings.svh"

module msr_file (
   input  logic                clk,
   input  logic                arst_n,
   input  msr_pkg::msr_wr_t    wr,
   input  msr_pkg::exc_upd_t   upd,
   output msr_pkg::msr_view_t  view
);

   msr_pkg::msr_psr_t                    psr_q;
   msr_pkg::msr_psr_t                    psr_apb;
   msr_pkg::msr_psr_t                    psr_nold;
   msr_pkg::msr_psr_t                    psr_byp;
   logic                                 psr_apb_we;
   logic                                 psr_ld;
   logic [`MSR_DW-1:0]                   epsr_q;
   logic [`MSR_DW-1:0]                   epc_q;
   logic [`MSR_DW-1:0]                   elsa_q;
   logic [`MSR_DW-1:0]                   epsr_nxt;
   logic [`MSR_DW-1:0]                   epc_nxt;
   logic [`MSR_DW-1:0]                   elsa_nxt;
   logic                                 epsr_we;
   logic                                 epc_we;
   logic                                 elsa_we;
   logic [`MSR_SR_NUM-1:0][`MSR_DW-1:0]  sr_q;

   // An event in the same cycle drops the software PSR write
   assign psr_apb_we = wr.psr_we & ~upd.ent & ~upd.ret;
   assign psr_apb    = msr_pkg::msr_psr_t'(wr.data);
   assign psr_ld     = psr_apb_we | upd.ent | upd.ret;

   // PSR as software sees it, before entry changes
   assign psr_nold = psr_apb_we ? psr_apb : psr_q;

   always_comb begin
      psr_byp = psr_nold;
      if (upd.ent) begin
         // Entry goes privileged with IRQs and MMUs off
         psr_byp.rm   = 1'b1;
         psr_byp.ire  = 1'b0;
         psr_byp.imme = 1'b0;
         psr_byp.dmme = 1'b0;
      end else if (upd.ret) begin
         psr_byp = upd.psr_rest;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr_q    <= '0;
         psr_q.rm <= 1'b1;
      end else if (psr_ld) begin
         psr_q <= psr_byp;
      end
   end

   // Saved exception state, entry has priority
   assign epsr_we  = upd.ent | wr.epsr_we;
   assign epc_we   = upd.ent | wr.epc_we;
   assign elsa_we  = upd.ent | wr.elsa_we;
   assign epsr_nxt = upd.ent ? upd.epsr_nxt : wr.data;
   assign epc_nxt  = upd.ent ? upd.epc_nxt : wr.data;
   assign elsa_nxt = upd.ent ? upd.elsa_nxt : wr.data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end else begin
         if (epsr_we) begin
            epsr_q <= epsr_nxt;
         end
         if (epc_we) begin
            epc_q <= epc_nxt;
         end
         if (elsa_we) begin
            elsa_q <= elsa_nxt;
         end
      end
   end

   // Scratch registers
   always_ff @(posedge clk) begin
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         if (wr.sr_we[i]) begin
            sr_q[i] <= wr.data;
         end
      end
   end

   // Bypassed views show this cycle's update
   always_comb begin
      view.psr.f           = psr_byp;
      view.psr_nold.f      = psr_nold;
      view.epsr.word       = epsr_we ? epsr_nxt : epsr_q;
      view.epsr_nobyp.word = epsr_q;
      view.epc             = epc_we ? epc_nxt : epc_q;
      view.elsa            = elsa_we ? elsa_nxt : elsa_q;
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         view.sr[i] = wr.sr_we[i] ? wr.data : sr_q[i];
      end
   end

endmodule

// ==== msr_exc_ctrl.sv ====
`include "msr_settings.svh"

module msr_exc_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   input  msr_pkg::exc_evt_t   evt,
   input  msr_pkg::msr_view_t  view,
   output msr_pkg::exc_upd_t   upd,
   output msr_pkg::redirect_t  redirect
);

   logic               ent;
   logic               ret;
   logic [`MSR_DW-1:0] vec_pc;
   logic               redir_valid_q;
   logic [`MSR_DW-1:0] redir_pc_q;

   assign ent = evt.valid & (evt.kind == msr_pkg::EXC_ENT);
   assign ret = evt.valid & (evt.kind == msr_pkg::EXC_RET);

   // One vector slot per cause
   assign vec_pc = `MSR_EVEC_BASE + evt.cause * `MSR_EVEC_STRIDE;

   always_comb begin
      upd.ent      = ent;
      upd.ret      = ret;
      // Save PSR without the entry changes
      upd.epsr_nxt = view.psr_nold.word;
      upd.epc_nxt  = evt.pc;
      upd.elsa_nxt = evt.lsa;
      // Restore only the live fields of the stored EPSR
      upd.psr_rest      = '0;
      upd.psr_rest.rm   = view.epsr_nobyp.f.rm;
      upd.psr_rest.ire  = view.epsr_nobyp.f.ire;
      upd.psr_rest.imme = view.epsr_nobyp.f.imme;
      upd.psr_rest.dmme = view.epsr_nobyp.f.dmme;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         redir_valid_q <= 1'b0;
      end else begin
         redir_valid_q <= evt.valid;
      end
   end

   // Target held one cycle, return uses EPC as seen now
   always_ff @(posedge clk) begin
      if (evt.valid) begin
         redir_pc_q <= ret ? view.epc : vec_pc;
      end
   end

   assign redirect = '{valid: redir_valid_q, pc: redir_pc_q};

endmodule

// ==== msr_apb_regs.sv ====
`include "msr_settings.svh"

module msr_apb_regs (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [`MSR_DW-1:0]  paddr,
   input  logic [`MSR_DW-1:0]  pwdata,
   output logic [`MSR_DW-1:0]  prdata,
   output logic                pready,
   output logic                pslverr,
   input  msr_pkg::msr_view_t  view,
   output msr_pkg::msr_wr_t    wr
);

   localparam logic [`MSR_DW-1:0] CPUID = {
      {(`MSR_DW-26){1'b0}},
      `MSR_CPUID_FTSC, `MSR_CPUID_FIRQC, `MSR_CPUID_FFPU, `MSR_CPUID_FDBG,
      `MSR_CPUID_FDCA, `MSR_CPUID_FICA, `MSR_CPUID_FDMM, `MSR_CPUID_FIMM,
      `MSR_CPUID_REV, `MSR_CPUID_VER
   };

   msr_pkg::msr_idx_e  idx;
   msr_pkg::msr_psr_u  psr_wd;
   msr_pkg::msr_psr_u  psr_msk;
   logic               setup_q;
   logic               access;
   logic               idx_hit;
   logic               addr_ok;
   logic               ro;
   logic               wr_ok;

   assign idx = msr_pkg::msr_idx_e'(paddr[5:2]);

   // Access only counts right after a setup cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel & ~penable;
      end
   end

   assign access = psel & penable & setup_q;
   assign pready = 1'b1;

   always_comb begin
      unique case (idx)
         msr_pkg::MSR_IDX_PSR,
         msr_pkg::MSR_IDX_CPUID,
         msr_pkg::MSR_IDX_EPSR,
         msr_pkg::MSR_IDX_EPC,
         msr_pkg::MSR_IDX_ELSA,
         msr_pkg::MSR_IDX_COREID,
         msr_pkg::MSR_IDX_SR0,
         msr_pkg::MSR_IDX_SR1,
         msr_pkg::MSR_IDX_SR2,
         msr_pkg::MSR_IDX_SR3: idx_hit = 1'b1;
         default:              idx_hit = 1'b0;
      endcase
   end

   // Word aligned and inside the 64-byte window
   assign addr_ok = idx_hit && (paddr[`MSR_DW-1:6] == '0) && (paddr[1:0] == 2'b00);
   assign ro      = (idx == msr_pkg::MSR_IDX_CPUID) || (idx == msr_pkg::MSR_IDX_COREID);
   assign pslverr = access & (~addr_ok | (pwrite & ro));
   assign wr_ok   = access & pwrite & addr_ok & ~ro;

   // PSR write keeps the four live fields
   always_comb begin
      psr_wd.word    = pwdata;
      psr_msk.word   = '0;
      psr_msk.f.rm   = psr_wd.f.rm;
      psr_msk.f.ire  = psr_wd.f.ire;
      psr_msk.f.imme = psr_wd.f.imme;
      psr_msk.f.dmme = psr_wd.f.dmme;
   end

   always_comb begin
      wr.psr_we  = wr_ok && (idx == msr_pkg::MSR_IDX_PSR);
      wr.epsr_we = wr_ok && (idx == msr_pkg::MSR_IDX_EPSR);
      wr.epc_we  = wr_ok && (idx == msr_pkg::MSR_IDX_EPC);
      wr.elsa_we = wr_ok && (idx == msr_pkg::MSR_IDX_ELSA);
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         wr.sr_we[i] = wr_ok && (int'(idx) == int'(msr_pkg::MSR_IDX_SR0) + i);
      end
      wr.data = (idx == msr_pkg::MSR_IDX_PSR) ? psr_msk.word : pwdata;
   end

   // Read data from the bypassed views
   always_comb begin
      unique case (idx)
         msr_pkg::MSR_IDX_PSR:    prdata = view.psr.word;
         msr_pkg::MSR_IDX_CPUID:  prdata = CPUID;
         msr_pkg::MSR_IDX_EPSR:   prdata = view.epsr.word;
         msr_pkg::MSR_IDX_EPC:    prdata = view.epc;
         msr_pkg::MSR_IDX_ELSA:   prdata = view.elsa;
         msr_pkg::MSR_IDX_COREID: prdata = '0;
         msr_pkg::MSR_IDX_SR0:    prdata = view.sr[0];
         msr_pkg::MSR_IDX_SR1:    prdata = view.sr[1];
         msr_pkg::MSR_IDX_SR2:    prdata = view.sr[2];
         msr_pkg::MSR_IDX_SR3:    prdata = view.sr[3];
         default:                 prdata = '0;
      endcase
   end

endmodule

// ==== msr_unit.sv ====
`include "msr_settings.svh"

module msr_unit (
   input  logic                clk,
   input  logic                arst_n,
   // APB slave
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [`MSR_DW-1:0]  paddr,
   input  logic [`MSR_DW-1:0]  pwdata,
   output logic [`MSR_DW-1:0]  prdata,
   output logic                pready,
   output logic                pslverr,
   // Pipeline events and fetch redirect
   input  msr_pkg::exc_evt_t   evt,
   output msr_pkg::redirect_t  redirect
);

   msr_pkg::msr_wr_t    wr;
   msr_pkg::exc_upd_t   upd;
   msr_pkg::msr_view_t  view;

   msr_apb_regs i_msr_apb_regs (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .view    (view),
      .wr      (wr)
   );

   msr_exc_ctrl i_msr_exc_ctrl (
      .clk      (clk),
      .arst_n   (arst_n),
      .evt      (evt),
      .view     (view),
      .upd      (upd),
      .redirect (redirect)
   );

   msr_file i_msr_file (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .upd    (upd),
      .view   (view)
   );

endmodule

// ==== msr_unit_assertions.sv ====
module msr_unit_assertions (
   input logic                clk,
   input logic                arst_n,
   input logic                psel,
   input logic                penable,
   input logic                pready,
   input msr_pkg::exc_evt_t   evt,
   input msr_pkg::redirect_t  redirect,
   input msr_pkg::msr_view_t  view
);

   // Access cycle follows a setup cycle and completes with no wait states
   a_pready: assert property (@(posedge clk) disable iff (!arst_n)
      (psel && penable) |-> (pready && $past(psel && !penable)))
      else $error("APB access cycle without a setup cycle or with pready low");

   // Redirect exactly one cycle after each event
   a_redir_after_evt: assert property (@(posedge clk) disable iff (!arst_n)
      evt.valid |=> redirect.valid)
      else $error("redirect missing one cycle after an event");

   a_redir_only_after_evt: assert property (@(posedge clk) disable iff (!arst_n)
      redirect.valid |-> $past(evt.valid))
      else $error("redirect without an event in the previous cycle");

   // Entry leaves the core privileged
   a_entry_rm: assert property (@(posedge clk) disable iff (!arst_n)
      (evt.valid && evt.kind == msr_pkg::EXC_ENT) |=> view.psr.f.rm)
      else $error("PSR RM clear in the cycle after an entry");

endmodule

bind msr_unit msr_unit_assertions i_msr_unit_assertions (
   .clk      (clk),
   .arst_n   (arst_n),
   .psel     (psel),
   .penable  (penable),
   .pready   (pready),
   .evt      (evt),
   .redirect (redirect),
   .view     (view)
);

// ==== msr_unit_tb.sv ====
`include "msr_settings.svh"

module msr_unit_tb;

   localparam int VEC_COLS = 6;
   localparam int VEC_MAX  = 64;
   localparam int WAIT_MAX = 8;

   logic                clk;
   logic                arst_n;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [`MSR_DW-1:0]  paddr;
   logic [`MSR_DW-1:0]  pwdata;
   logic [`MSR_DW-1:0]  prdata;
   logic                pready;
   logic                pslverr;
   msr_pkg::exc_evt_t   evt;
   msr_pkg::redirect_t  redirect;

   // op, arg, data, lsa, expected value, expected error
   logic [`MSR_DW-1:0]  vec_mem [0:VEC_COLS*VEC_MAX-1];
   int                  n_run;

   msr_unit i_msr_unit (
      .clk      (clk),
      .arst_n   (arst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .evt      (evt),
      .redirect (redirect)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_rdata(input string name, input logic [`MSR_DW-1:0] exp,
                              input logic [`MSR_DW-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected pslverr %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_redirect(input string name, input msr_pkg::redirect_t exp,
                                 input msr_pkg::redirect_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected valid %b pc %h, actual valid %b pc %h",
                  name, exp.valid, exp.pc, act.valid, act.pc);
         abort_run();
      end
   endtask

   // Setup cycle then access cycle, sampled at the falling edge
   task automatic apb_xfer(input logic wr_en, input logic [`MSR_DW-1:0] addr,
                           input logic [`MSR_DW-1:0] data,
                           output logic [`MSR_DW-1:0] rdata, output logic err);
      int waited;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr_en;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #2;
      penable = 1'b1;
      waited  = 0;
      @(negedge clk);
      while (!pready) begin
         waited++;
         if (waited > WAIT_MAX) begin
            $display("APB transfer to address %h was never completed", addr);
            abort_run();
         end
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // One-cycle event strobe, then wait for the redirect
   task automatic send_event(input msr_pkg::exc_kind_e kind, input logic [3:0] cause,
                             input logic [`MSR_DW-1:0] pc, input logic [`MSR_DW-1:0] lsa,
                             output msr_pkg::redirect_t seen);
      int waited;
      evt.valid = 1'b1;
      evt.kind  = kind;
      evt.cause = cause;
      evt.pc    = pc;
      evt.lsa   = lsa;
      @(posedge clk);
      #2;
      evt.valid = 1'b0;
      waited    = 0;
      @(negedge clk);
      while (!redirect.valid) begin
         waited++;
         if (waited > WAIT_MAX) begin
            $display("No fetch redirect came after the exception event");
            abort_run();
         end
         @(negedge clk);
      end
      seen = redirect;
      @(posedge clk);
      #2;
   endtask

   initial begin
      int                  base;
      logic [`MSR_DW-1:0]  op;
      logic [`MSR_DW-1:0]  rdata;
      logic                err;
      msr_pkg::redirect_t  seen;
      msr_pkg::redirect_t  want;
      string               name;
      clk     = 1'b0;
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      evt     = '0;
      n_run   = 0;
      $readmemh("msr_unit_vectors.txt", vec_mem);
      repeat (16) @(posedge clk);
      #2;
      arst_n = 1'b1;
      @(posedge clk);
      #2;
      for (int v = 0; v < VEC_MAX; v++) begin
         base = v * VEC_COLS;
         op   = vec_mem[base];
         if (op === 32'hf) begin
            break;
         end
         want.valid = 1'b1;
         want.pc    = vec_mem[base+4];
         case (op)
            0: begin
               name = $sformatf("vector %0d write %h", v, vec_mem[base+1]);
               apb_xfer(1'b1, vec_mem[base+1], vec_mem[base+2], rdata, err);
               check_err(name, vec_mem[base+5][0], err);
            end
            1: begin
               name = $sformatf("vector %0d read %h", v, vec_mem[base+1]);
               apb_xfer(1'b0, vec_mem[base+1], '0, rdata, err);
               check_rdata(name, vec_mem[base+4], rdata);
               check_err(name, vec_mem[base+5][0], err);
            end
            2: begin
               name = $sformatf("vector %0d entry cause %0d", v, vec_mem[base+1][3:0]);
               send_event(msr_pkg::EXC_ENT, vec_mem[base+1][3:0], vec_mem[base+2],
                          vec_mem[base+3], seen);
               check_redirect(name, want, seen);
            end
            3: begin
               name = $sformatf("vector %0d return", v);
               send_event(msr_pkg::EXC_RET, 4'd0, '0, '0, seen);
               check_redirect(name, want, seen);
            end
            default: begin
               $display("Vector %0d holds an unknown operation %h", v, op);
               abort_run();
            end
         endcase
         n_run++;
      end
      if (n_run > 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("No vectors were read from msr_unit_vectors.txt");
         abort_run();
      end
   end

endmodule

// ==== msr_unit_vectors.txt ====
// op arg data lsa expect err, all hex
// op 0 write, 1 read, 2 entry (arg is cause), 3 return, f ends the list
1 00 00000000 00000000 00000010 0
1 04 00000000 00000000 030c0001 0
1 08 00000000 00000000 00000000 0
1 0c 00000000 00000000 00000000 0
1 10 00000000 00000000 00000000 0
1 14 00000000 00000000 00000000 0
0 20 a5a5a5a5 00000000 00000000 0
0 24 5a5a5a5a 00000000 00000000 0
0 28 12345678 00000000 00000000 0
0 2c cafef00d 00000000 00000000 0
1 20 00000000 00000000 a5a5a5a5 0
1 24 00000000 00000000 5a5a5a5a 0
1 28 00000000 00000000 12345678 0
1 2c 00000000 00000000 cafef00d 0
0 0c 00002000 00000000 00000000 0
1 0c 00000000 00000000 00002000 0
0 10 00003004 00000000 00000000 0
1 10 00000000 00000000 00003004 0
0 00 ffffffff 00000000 00000000 0
1 00 00000000 00000000 000000f0 0
0 04 deadbeef 00000000 00000000 1
1 04 00000000 00000000 030c0001 0
0 14 deadbeef 00000000 00000000 1
1 14 00000000 00000000 00000000 0
0 18 11111111 00000000 00000000 1
1 18 00000000 00000000 00000000 1
1 3c 00000000 00000000 00000000 1
1 20 00000000 00000000 a5a5a5a5 0
2 03 00004000 00005008 00000130 0
1 08 00000000 00000000 000000f0 0
1 0c 00000000 00000000 00004000 0
1 10 00000000 00000000 00005008 0
1 00 00000000 00000000 00000010 0
0 08 ffffff5f 00000000 00000000 0
0 0c 00006000 00000000 00000000 0
1 08 00000000 00000000 ffffff5f 0
3 00 00000000 00000000 00006000 0
1 00 00000000 00000000 00000050 0
0 00 00000070 00000000 00000000 0
2 07 00007000 00008000 00000170 0
1 08 00000000 00000000 00000070 0
1 00 00000000 00000000 00000010 0
3 00 00000000 00000000 00007000 0
1 00 00000000 00000000 00000070 0
f 00 00000000 00000000 00000000 0

// ==== msr_unit.f ====
+incdir+.
msr_pkg.sv
msr_file.sv
msr_exc_ctrl.sv
msr_apb_regs.sv
msr_unit.sv
msr_unit_assertions.sv
msr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the msr_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module msr_unit_tb \
   -f msr_unit.f -o msr_unit_sim || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/msr_unit_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "^Test completed successfully$" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
